// ==== rtl/bus_pkg.sv ====
// Shared cycle kinds, request and response structs and bus timing constants for the bus unit
`default_nettype none

package bus_pkg;

  // Machine cycle kinds that the request port accepts
  typedef enum logic [2:0] {
    kind_fetch,
    kind_mem_rd,
    kind_mem_wr,
    kind_io_rd,
    kind_io_wr,
    kind_inta
  } bus_kind_e;

  // One bus operation as issued by the master
  // Address and write data are ignored where the kind does not need them
  typedef struct packed {
    bus_kind_e   kind;
    logic [15:0] addr;
    logic [7:0]  wdata;
  } bus_req_t;

  // Result of one bus operation, returned in request order
  // A write cycle returns zero in rdata
  typedef struct packed {
    bus_kind_e  kind;
    logic [7:0] rdata;
  } bus_rsp_t;

  // T-state of the machine cycle in progress
  // Tw may repeat, T4 only exists for an opcode fetch
  typedef enum logic [2:0] {
    ts_idle,
    ts_t1,
    ts_t2,
    ts_tw,
    ts_t3,
    ts_t4
  } tstate_e;

  // Wait states inserted ahead of wait_n sampling on I/O and INTA cycles
  localparam int io_auto_waits = 1;

  // Width of the refresh counter that forms the low refresh address bits
  localparam int refresh_bits = 7;

endpackage

`default_nettype wire

// ==== rtl/bus_stage_reg.sv ====
// One-entry valid/ready holding register, instantiated for the request and the response payload
`default_nettype none

module bus_stage_reg #(
  parameter type payload_t = logic [7:0]
) (
  input  wire logic clk,
  input  wire logic reset_n,
  input  wire logic in_valid,
  output logic      in_ready,
  input  payload_t  in_data,
  output logic      out_valid,
  input  wire logic out_ready,
  output payload_t  out_data
);

  // Entry occupancy flag
  logic     full;
  // Goes high one clock after reset is released and keeps the stage closed until then
  logic     started;
  // Held payload
  payload_t data_q;

  // The stage can take a new item when it is empty or is being drained on the same edge
  assign in_ready  = started && (!full || out_ready);
  assign out_valid = full;
  assign out_data  = data_q;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      started <= 1'b0;
      full    <= 1'b0;
    end
    else
    begin
      started <= 1'b1;
      // A load wins over a drain, so a pass-through edge keeps the entry full
      if (in_valid && in_ready)
        full <= 1'b1;
      else if (out_ready)
        full <= 1'b0;
    end
  end

  // Payload only moves on an accepted transfer
  always_ff @(posedge clk)
  begin
    if (in_valid && in_ready)
      data_q <= in_data;
  end

  // Under back-pressure the consumer must see the same item on the next edge
  a_hold_stable : assert property (
    @(posedge clk) disable iff (!reset_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
  );

endmodule

`default_nettype wire

// ==== rtl/bus_tstate_seq.sv ====
// Machine-cycle sequencer that walks T-states, inserts waits and drives address, data and response
`default_nettype none

module bus_tstate_seq import bus_pkg::*; (
  input  wire logic        clk,
  input  wire logic        reset_n,
  input  wire logic        cur_valid,
  output logic             cur_ready,
  input  bus_req_t         cur_req,
  input  wire logic        wait_n,
  input  wire logic [7:0]  read_data,
  output logic             rsp_valid,
  input  wire logic        rsp_ready,
  output bus_rsp_t         rsp,
  output bus_kind_e        kind,
  output tstate_e          tstate,
  output logic             cycle_done,
  output logic [15:0]      addr,
  output logic [7:0]       dout
);

  // Request being executed on the bus
  bus_req_t                 req_q;
  // Forced I/O waits still to be inserted
  logic [1:0]               forced_cnt;
  // Refresh counter, advanced once per opcode fetch
  logic [refresh_bits-1:0]  rfsh_cnt;
  logic                     accept;
  logic                     new_is_io;
  logic                     is_write;
  logic                     refresh_sel;
  logic [15:0]              refresh_addr;

  // A cycle starts only from idle and only if its response will have a place to go
  assign cur_ready = (tstate == ts_idle) && rsp_ready;
  assign accept    = cur_valid && cur_ready;

  // I/O and interrupt acknowledge cycles get the automatic wait states
  assign new_is_io = (cur_req.kind == kind_io_rd) || (cur_req.kind == kind_io_wr) ||
                     (cur_req.kind == kind_inta);

  assign kind     = req_q.kind;
  assign is_write = (req_q.kind == kind_mem_wr) || (req_q.kind == kind_io_wr);

  // Fetches end in T4, every other kind ends in T3
  assign cycle_done = (tstate == ts_t4) ||
                      ((tstate == ts_t3) && (req_q.kind != kind_fetch));

  // The refresh address has a zero high byte and a zero bit 7
  assign refresh_sel  = (req_q.kind == kind_fetch) && ((tstate == ts_t3) || (tstate == ts_t4));
  assign refresh_addr = {{(16 - refresh_bits){1'b0}}, rfsh_cnt};

  // The response is offered in the last T-state and taken by the response stage on that edge
  assign rsp_valid  = cycle_done;
  assign rsp.kind   = req_q.kind;
  assign rsp.rdata  = is_write ? 8'h00 : read_data;

  always_ff @(posedge clk)
  begin
    if (accept)
      req_q <= cur_req;
  end

  // T-state walk
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      tstate     <= ts_idle;
      forced_cnt <= 2'd0;
    end
    else
    begin
      case (tstate)
        ts_idle:
        begin
          if (accept)
          begin
            tstate     <= ts_t1;
            forced_cnt <= new_is_io ? 2'(io_auto_waits) : 2'd0;
          end
        end
        ts_t1:
          tstate <= ts_t2;
        ts_t2, ts_tw:
        begin
          // Forced waits come first and ignore wait_n
          if (forced_cnt != 2'd0)
          begin
            tstate     <= ts_tw;
            forced_cnt <= forced_cnt - 2'd1;
          end
          else if (!wait_n)
            tstate <= ts_tw;
          else
            tstate <= ts_t3;
        end
        ts_t3:
          tstate <= (req_q.kind == kind_fetch) ? ts_t4 : ts_idle;
        default:
          tstate <= ts_idle;
      endcase
    end
  end

  // Refresh count moves on once the fetch has finished its T4
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      rfsh_cnt <= '0;
    else if ((tstate == ts_t4) && (req_q.kind == kind_fetch))
      rfsh_cnt <= rfsh_cnt + 1'b1;
  end

  // Address is registered from the decoded T-state, so it lines up with the strobes
  // It keeps its last value while idle
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      addr <= 16'h0000;
    else if (refresh_sel)
      addr <= refresh_addr;
    else if (tstate != ts_idle)
      addr <= req_q.addr;
  end

  // Write data is placed on the bus from T1 and held until the next cycle
  always_ff @(posedge clk)
  begin
    if (tstate == ts_t1)
      dout <= req_q.wdata;
  end

  // Leaving idle always goes with an accepted request
  a_start_on_accept : assert property (
    @(posedge clk) disable iff (!reset_n)
    ((tstate == ts_idle) && !accept) |=> (tstate == ts_idle)
  );

  // The response stage must have room whenever a cycle completes
  a_rsp_room : assert property (
    @(posedge clk) disable iff (!reset_n)
    rsp_valid |-> rsp_ready
  );

endmodule

`default_nettype wire

// ==== rtl/bus_strobe_gen.sv ====
// Registered active-low bus strobe decoder and read data latch, driven by the T-state sequencer
`default_nettype none

module bus_strobe_gen import bus_pkg::*; (
  input  wire logic        clk,
  input  wire logic        reset_n,
  input  bus_kind_e        kind,
  input  tstate_e          tstate,
  input  wire logic        cycle_done,
  input  wire logic        wait_n,
  input  wire logic [7:0]  din,
  output logic             m1_n,
  output logic             mreq_n,
  output logic             iorq_n,
  output logic             rd_n,
  output logic             wr_n,
  output logic             rfsh_n,
  output logic [7:0]       read_data
);

  // Active-high decode of each strobe for the next clock
  logic m1_d;
  logic mreq_d;
  logic iorq_d;
  logic rd_d;
  logic wr_d;
  logic rfsh_d;
  // T1 up to the last wait state
  logic access_phase;
  // T2 and wait states only
  logic data_phase;
  // T3 and the closing T4 of a fetch
  logic refresh_phase;

  assign access_phase  = (tstate == ts_t1) || (tstate == ts_t2) || (tstate == ts_tw);
  assign data_phase    = (tstate == ts_t2) || (tstate == ts_tw);
  // For a fetch the cycle ends in T4, so cycle_done marks the second refresh state
  assign refresh_phase = (kind == kind_fetch) && ((tstate == ts_t3) || cycle_done);

  always_comb
  begin
    m1_d   = 1'b0;
    mreq_d = 1'b0;
    iorq_d = 1'b0;
    rd_d   = 1'b0;
    wr_d   = 1'b0;
    rfsh_d = 1'b0;
    if (access_phase)
    begin
      case (kind)
        kind_fetch:
        begin
          m1_d   = 1'b1;
          mreq_d = 1'b1;
          rd_d   = 1'b1;
        end
        kind_mem_rd:
        begin
          mreq_d = 1'b1;
          rd_d   = 1'b1;
        end
        kind_mem_wr:
        begin
          mreq_d = 1'b1;
          // Write strobe only in T2 and waits, address and data are already settled
          wr_d   = data_phase;
        end
        kind_io_rd:
        begin
          iorq_d = 1'b1;
          rd_d   = 1'b1;
        end
        kind_io_wr:
        begin
          iorq_d = 1'b1;
          wr_d   = data_phase;
        end
        kind_inta:
        begin
          // M1 marks the acknowledge, iorq_n reaches the bus with the forced wait
          m1_d   = 1'b1;
          iorq_d = data_phase;
        end
        default:
        begin
          m1_d = 1'b0;
        end
      endcase
    end
    // Refresh keeps mreq_n low while the refresh address is out, rd_n goes high
    if (refresh_phase)
    begin
      mreq_d = 1'b1;
      rfsh_d = 1'b1;
    end
  end

  // Strobes are one clock behind the decoded T-state and all high after reset
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      m1_n   <= 1'b1;
      mreq_n <= 1'b1;
      iorq_n <= 1'b1;
      rd_n   <= 1'b1;
      wr_n   <= 1'b1;
      rfsh_n <= 1'b1;
    end
    else
    begin
      m1_n   <= ~m1_d;
      mreq_n <= ~mreq_d;
      iorq_n <= ~iorq_d;
      rd_n   <= ~rd_d;
      wr_n   <= ~wr_d;
      rfsh_n <= ~rfsh_d;
    end
  end

  // Every T2 or Tw with wait_n high samples din, the last one before T3 is what is kept
  always_ff @(posedge clk)
  begin
    if (data_phase && wait_n)
      read_data <= din;
  end

  a_rd_wr_excl : assert property (
    @(posedge clk) disable iff (!reset_n)
    !(!rd_n && !wr_n)
  );

  a_mreq_iorq_excl : assert property (
    @(posedge clk) disable iff (!reset_n)
    !(!mreq_n && !iorq_n)
  );

  // Refresh is only ever a memory request
  a_rfsh_with_mreq : assert property (
    @(posedge clk) disable iff (!reset_n)
    !rfsh_n |-> !mreq_n
  );

endmodule

`default_nettype wire

// ==== rtl/bus_unit_top.sv ====
// Bus unit top level that joins the request stage, sequencer, strobe decoder and response stage
`default_nettype none

module bus_unit_top import bus_pkg::*; (
  input  wire logic        clk,
  input  wire logic        reset_n,
  input  wire logic        req_valid,
  output logic             req_ready,
  input  bus_req_t         req,
  output logic             rsp_valid,
  input  wire logic        rsp_ready,
  output bus_rsp_t         rsp,
  output logic [15:0]      addr,
  output logic [7:0]       dout,
  input  wire logic [7:0]  din,
  input  wire logic        wait_n,
  output logic             m1_n,
  output logic             mreq_n,
  output logic             iorq_n,
  output logic             rd_n,
  output logic             wr_n,
  output logic             rfsh_n
);

  // Request stage to sequencer
  logic       cur_valid;
  logic       cur_ready;
  bus_req_t   cur_req;
  // Sequencer to response stage
  logic       seq_rsp_valid;
  logic       seq_rsp_ready;
  bus_rsp_t   seq_rsp;
  // Sequencer to strobe decoder
  bus_kind_e  kind;
  tstate_e    tstate;
  logic       cycle_done;
  // Latched read byte back to the sequencer
  logic [7:0] read_data;

  bus_stage_reg #(
    .payload_t (bus_req_t)
  ) req_stage_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_valid  (req_valid),
    .in_ready  (req_ready),
    .in_data   (req),
    .out_valid (cur_valid),
    .out_ready (cur_ready),
    .out_data  (cur_req)
  );

  bus_tstate_seq seq_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .cur_valid  (cur_valid),
    .cur_ready  (cur_ready),
    .cur_req    (cur_req),
    .wait_n     (wait_n),
    .read_data  (read_data),
    .rsp_valid  (seq_rsp_valid),
    .rsp_ready  (seq_rsp_ready),
    .rsp        (seq_rsp),
    .kind       (kind),
    .tstate     (tstate),
    .cycle_done (cycle_done),
    .addr       (addr),
    .dout       (dout)
  );

  bus_strobe_gen strobe_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .kind       (kind),
    .tstate     (tstate),
    .cycle_done (cycle_done),
    .wait_n     (wait_n),
    .din        (din),
    .m1_n       (m1_n),
    .mreq_n     (mreq_n),
    .iorq_n     (iorq_n),
    .rd_n       (rd_n),
    .wr_n       (wr_n),
    .rfsh_n     (rfsh_n),
    .read_data  (read_data)
  );

  // The response stage ready also gates new cycles in the sequencer
  bus_stage_reg #(
    .payload_t (bus_rsp_t)
  ) rsp_stage_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_valid  (seq_rsp_valid),
    .in_ready  (seq_rsp_ready),
    .in_data   (seq_rsp),
    .out_valid (rsp_valid),
    .out_ready (rsp_ready),
    .out_data  (rsp)
  );

endmodule

`default_nettype wire

// ==== dv/tb_bus_memory.sv ====
// Bus-side model of memory, I/O space and interrupt vector, answers the strobes and reports writes
`default_nettype none

module tb_bus_memory #(
  parameter logic [7:0] vector = 8'hff
) (
  input  wire logic        clk,
  input  wire logic        reset_n,
  input  wire logic [15:0] addr,
  input  wire logic [7:0]  dout,
  input  wire logic        m1_n,
  input  wire logic        mreq_n,
  input  wire logic        iorq_n,
  input  wire logic        rd_n,
  input  wire logic        wr_n,
  input  wire logic        rfsh_n,
  output logic [7:0]       din,
  output logic             wr_seen,
  output logic             wr_io,
  output logic [15:0]      wr_addr,
  output logic [7:0]       wr_data,
  output logic             rfsh_seen,
  output logic [15:0]      rfsh_addr
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0]  mem [0:65535];
  logic [7:0]  io [0:255];
  // Bus contents captured while wr_n is low
  logic [15:0] hold_addr;
  logic [7:0]  hold_data;
  logic        hold_io;
  // Strobe levels at the previous falling edge, for edge detection
  logic        wr_prev_n;
  logic        rfsh_prev_n;

  // Each image byte depends on every bit of its address
  function automatic logic [7:0] mem_fill(logic [15:0] a);
    return a[15:8] ^ {a[3:0], a[7:4]} ^ 8'h96;
  endfunction

  function automatic logic [7:0] io_fill(logic [7:0] p);
    return p ^ 8'hc3;
  endfunction

  initial
  begin
    for (int i = 0; i < 65536; i++)
      mem[16'(i)] = mem_fill(16'(i));
    for (int i = 0; i < 256; i++)
      io[8'(i)] = io_fill(8'(i));
  end

  // Read data is offered only to the strobe combination that owns it
  always_comb
  begin
    din = 8'hee;
    if (!mreq_n && !rd_n)
      din = mem[addr];
    else if (!iorq_n && !rd_n && m1_n)
      din = io[addr[7:0]];
    else if (!m1_n && !iorq_n)
      din = vector;
  end

  // Strobes move on the rising edge, so the falling edge sees a settled bus
  always @(negedge clk)
  begin
    if (!reset_n)
    begin
      wr_seen     <= 1'b0;
      rfsh_seen   <= 1'b0;
      wr_prev_n   <= 1'b1;
      rfsh_prev_n <= 1'b1;
    end
    else
    begin
      wr_seen   <= 1'b0;
      rfsh_seen <= 1'b0;
      if (!wr_n)
      begin
        hold_addr <= addr;
        hold_data <= dout;
        hold_io   <= !iorq_n;
      end
      // The write completes when wr_n goes back high
      if (!wr_prev_n && wr_n)
      begin
        wr_seen <= 1'b1;
        wr_io   <= hold_io;
        wr_addr <= hold_addr;
        wr_data <= hold_data;
        if (hold_io)
          io[hold_addr[7:0]] = hold_data;
        else
          mem[hold_addr] = hold_data;
      end
      // One log entry per refresh, taken on its first low clock
      if (!rfsh_n && rfsh_prev_n)
      begin
        rfsh_seen <= 1'b1;
        rfsh_addr <= addr;
      end
      wr_prev_n   <= wr_n;
      rfsh_prev_n <= rfsh_n;
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_bus_unit.sv ====
// Self-checking testbench for the bus unit, random bus operations checked against shadow images
`default_nettype none

module tb_bus_unit import bus_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_req = 600;
  localparam int clk_half = 50;
  localparam int reset_cycles = 8;
  localparam int clocks_per_req = 40;
  localparam int timeout_ns = (reset_cycles + num_req * clocks_per_req) * 2 * clk_half;
  localparam logic [7:0] int_vector = 8'hd7;
  localparam logic [15:0] lfsr_seed = 16'd23685;

  // One completed bus write as the memory model saw it
  typedef struct packed {
    logic        io;
    logic [15:0] addr;
    logic [7:0]  data;
  } wr_rec_t;

  logic        clk;
  logic        reset_n;
  logic        req_valid;
  logic        req_ready;
  bus_req_t    req;
  logic        rsp_valid;
  logic        rsp_ready;
  bus_rsp_t    rsp;
  logic [15:0] addr;
  logic [7:0]  dout;
  logic [7:0]  din;
  logic        wait_n;
  logic        m1_n;
  logic        mreq_n;
  logic        iorq_n;
  logic        rd_n;
  logic        wr_n;
  logic        rfsh_n;
  logic        wr_seen;
  logic        wr_io;
  logic [15:0] wr_addr;
  logic [7:0]  wr_data;
  logic        rfsh_seen;
  logic [15:0] rfsh_addr;

  // Shadow images and the expected results in bus order
  logic [7:0]              shadow_mem [0:65535];
  logic [7:0]              shadow_io [0:255];
  bus_rsp_t                exp_rsp_q[$];
  wr_rec_t                 exp_wr_q[$];
  logic [refresh_bits-1:0] exp_rfsh_q[$];
  logic [refresh_bits-1:0] rfsh_next;
  logic [15:0]             lfsr_state;
  int                      error_count;

  initial clk = 1'b0;
  always #(clk_half) clk = ~clk;

  bus_unit_top bus_unit_top_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .addr      (addr),
    .dout      (dout),
    .din       (din),
    .wait_n    (wait_n),
    .m1_n      (m1_n),
    .mreq_n    (mreq_n),
    .iorq_n    (iorq_n),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .rfsh_n    (rfsh_n)
  );

  tb_bus_memory #(
    .vector (int_vector)
  ) memory_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .addr      (addr),
    .dout      (dout),
    .m1_n      (m1_n),
    .mreq_n    (mreq_n),
    .iorq_n    (iorq_n),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .rfsh_n    (rfsh_n),
    .din       (din),
    .wr_seen   (wr_seen),
    .wr_io     (wr_io),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rfsh_seen (rfsh_seen),
    .rfsh_addr (rfsh_addr)
  );

  // Same fill rule as the memory model
  function automatic logic [7:0] mem_fill(logic [15:0] a);
    return a[15:8] ^ {a[3:0], a[7:4]} ^ 8'h96;
  endfunction

  function automatic logic [7:0] io_fill(logic [7:0] p);
    return p ^ 8'hc3;
  endfunction

  // Fibonacci LFSR with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[14:0], lfsr_state[0]};
    end
  endtask

  // Expected response of one request
  // Writes also update the shadow images
  function automatic bus_rsp_t expect_rsp(bus_req_t r);
    bus_rsp_t e;
    e.kind  = r.kind;
    e.rdata = 8'h00;
    case (r.kind)
      kind_fetch, kind_mem_rd: e.rdata = shadow_mem[r.addr];
      kind_mem_wr:             shadow_mem[r.addr] = r.wdata;
      kind_io_rd:              e.rdata = shadow_io[r.addr[7:0]];
      kind_io_wr:              shadow_io[r.addr[7:0]] = r.wdata;
      kind_inta:               e.rdata = int_vector;
      default:                 e.rdata = 8'h00;
    endcase
    return e;
  endfunction

  task automatic fail_run(input string why);
    error_count++;
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_rsp(input bus_rsp_t expected, input bus_rsp_t actual);
    if (actual !== expected)
      fail_run({$sformatf("CHECK FAILED at %0d ns: rsp exp kind=%0d rdata=%02h",
                          $time, expected.kind, expected.rdata),
                $sformatf(" got kind=%0d rdata=%02h", actual.kind, actual.rdata)});
  endtask

  task automatic check_write(input wr_rec_t expected, input wr_rec_t actual);
    if (actual !== expected)
      fail_run({$sformatf("CHECK FAILED at %0d ns: write exp io=%0b addr=%04h data=%02h",
                          $time, expected.io, expected.addr, expected.data),
                $sformatf(" got io=%0b addr=%04h data=%02h",
                          actual.io, actual.addr, actual.data)});
  endtask

  task automatic check_refresh(input logic [refresh_bits-1:0] expected,
                               input logic [refresh_bits-1:0] actual);
    if (actual !== expected)
      fail_run($sformatf("CHECK FAILED at %0d ns: rfsh count exp %0d got %0d",
                         $time, expected, actual));
  endtask

  // Falling edge drive of the random rsp_ready and wait_n levels
  task automatic next_cycle();
    logic [15:0] bits;
    @(negedge clk);
    take_bits(2, bits);
    rsp_ready = (bits[1:0] != 2'b00);
    take_bits(2, bits);
    wait_n = (bits[1:0] != 2'b00);
  endtask

  // Six kinds with half of the addresses packed into 16 locations so that reads hit writes
  task automatic make_request(output bus_req_t r);
    logic [15:0] bits;
    take_bits(3, bits);
    case (bits[2:0])
      3'd0, 3'd6: r.kind = kind_fetch;
      3'd1, 3'd7: r.kind = kind_mem_rd;
      3'd2:       r.kind = kind_mem_wr;
      3'd3:       r.kind = kind_io_rd;
      3'd4:       r.kind = kind_io_wr;
      default:    r.kind = kind_inta;
    endcase
    take_bits(1, bits);
    if (bits[0])
    begin
      take_bits(4, bits);
      r.addr = {12'h000, bits[3:0]};
    end
    else
    begin
      take_bits(16, bits);
      r.addr = bits;
    end
    take_bits(8, bits);
    r.wdata = bits[7:0];
  endtask

  initial
  begin : stimulus
    bus_req_t    r;
    wr_rec_t     w;
    logic [15:0] bits;
    lfsr_state  = lfsr_seed;
    error_count = 0;
    rfsh_next   = '0;
    reset_n     = 1'b0;
    req_valid   = 1'b0;
    req         = '0;
    rsp_ready   = 1'b0;
    wait_n      = 1'b1;
    for (int i = 0; i < 65536; i++)
      shadow_mem[16'(i)] = mem_fill(16'(i));
    for (int i = 0; i < 256; i++)
      shadow_io[8'(i)] = io_fill(8'(i));
    repeat (reset_cycles) @(negedge clk);
    reset_n = 1'b1;
    for (int n = 0; n < num_req; n++)
    begin
      make_request(r);
      exp_rsp_q.push_back(expect_rsp(r));
      if ((r.kind == kind_mem_wr) || (r.kind == kind_io_wr))
      begin
        w.io   = (r.kind == kind_io_wr);
        w.addr = r.addr;
        w.data = r.wdata;
        exp_wr_q.push_back(w);
      end
      // Each fetch is followed by one refresh with the next count
      if (r.kind == kind_fetch)
      begin
        exp_rfsh_q.push_back(rfsh_next);
        rfsh_next = rfsh_next + 1'b1;
      end
      req       = r;
      req_valid = 1'b1;
      #1;
      while (!req_ready)
      begin
        next_cycle();
        #1;
      end
      next_cycle();
      take_bits(2, bits);
      if (bits[1:0] == 2'b00)
      begin
        req_valid = 1'b0;
        next_cycle();
      end
    end
    req_valid = 1'b0;
    while ((exp_rsp_q.size() != 0) || (exp_wr_q.size() != 0) || (exp_rfsh_q.size() != 0))
      next_cycle();
    repeat (4) next_cycle();
    if (error_count == 0)
    begin
      $display("** PASS **");
      $finish;
    end
    else
    begin
      $display("** FAIL **");
      $fatal(1, "errors were counted");
    end
  end

  // Outputs settle after the rising edge and are read just after the falling edge
  always @(negedge clk)
  begin : compare
    wr_rec_t got_w;
    // Set by an M1 memory read, cleared by the refresh that has to follow it
    logic    m1_fetch_seen;
    #1;
    if (reset_n)
    begin
      if (rsp_valid && rsp_ready)
      begin
        if (exp_rsp_q.size() == 0)
          fail_run("A response came out with no request outstanding");
        else
          check_rsp(exp_rsp_q.pop_front(), rsp);
      end
      if (wr_seen)
      begin
        got_w.io   = wr_io;
        got_w.addr = wr_addr;
        got_w.data = wr_data;
        if (exp_wr_q.size() == 0)
          fail_run("A bus write happened that no request asked for");
        else
          check_write(exp_wr_q.pop_front(), got_w);
      end
      if (rfsh_seen)
      begin
        if (exp_rfsh_q.size() == 0)
          fail_run("A refresh happened without an opcode fetch");
        else
          check_refresh(exp_rfsh_q.pop_front(), rfsh_addr[refresh_bits-1:0]);
        if (rfsh_addr[15:refresh_bits] != '0)
          fail_run($sformatf("CHECK FAILED at %0d ns: rfsh addr high bits exp 0 got %04h",
                             $time, rfsh_addr));
        if (!m1_fetch_seen)
          fail_run("An opcode fetch read memory without m1_n low");
        m1_fetch_seen = 1'b0;
      end
      if (!m1_n && !mreq_n && !rd_n)
        m1_fetch_seen = 1'b1;
      // Interrupt acknowledge is the only M1 cycle with rd_n high outside refresh
      if (!m1_n && rd_n && !mreq_n)
        fail_run("mreq_n went low during an interrupt acknowledge");
    end
    else
      m1_fetch_seen = 1'b0;
  end

  // Each request is given 40 clocks in the worst case
  initial
  begin : watchdog
    #(timeout_ns);
    $display("Timeout, the run did not finish within %0d ns", timeout_ns);
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/bus_pkg.sv
rtl/bus_stage_reg.sv
rtl/bus_tstate_seq.sv
rtl/bus_strobe_gen.sv
rtl/bus_unit_top.sv
dv/tb_bus_memory.sv
dv/tb_bus_unit.sv

// ==== Makefile ====
# Verilator build and run of the bus unit testbench
# The run fails through $fatal, which gives a non-zero exit status

VERILATOR ?= verilator
TOP       ?= tb_bus_unit
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
